// File: src/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int XLEN = 32;

    // basic bus types
    typedef logic [XLEN-1:0]     addr_t;
    typedef logic [XLEN-1:0]     word_t;
    typedef logic [XLEN/8-1:0]   strb_t;
    typedef logic [XLEN-1:0]     inst_t;
    typedef logic [2*XLEN-1:0]   mtime_t;

    // AXI4-Lite response codes, only the two used here
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // data and instruction RAM
    localparam int    MEM_WORDS = 256;
    localparam int    MEM_IDX_W = 8;
    localparam addr_t RAM_LIMIT = addr_t'(MEM_WORDS * 4);
    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    // instruction queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_IDX_W = 2;
    localparam int INST_STEP   = 4;
    typedef logic [QUEUE_IDX_W-1:0] qidx_t;
    typedef logic [QUEUE_IDX_W:0]   qcnt_t;

    // time base, clock cycles per microsecond
    localparam int FMAX_MHZ = 18;
    localparam int US_CNT_W = 5;
    typedef logic [US_CNT_W-1:0] us_cnt_t;

    // timer register map
    localparam addr_t ADDR_MTIME_LO    = 32'h0000_8000;
    localparam addr_t ADDR_MTIME_HI    = 32'h0000_8004;
    localparam addr_t ADDR_MTIMECMP_LO = 32'h0000_8008;
    localparam addr_t ADDR_MTIMECMP_HI = 32'h0000_800C;

endpackage

`default_nettype wire

// File: src/ifetch_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ifetch_if
    import soc_pkg::*;
();

    // request side, owned by the queue
    logic  req_valid;
    addr_t req_addr;

    // returned by the memory controller one cycle after transfer
    logic  req_ready;
    logic  resp_valid;
    inst_t resp_inst;

    modport master (
        output req_valid, req_addr,
        input  req_ready, resp_valid, resp_inst
    );

    modport slave (
        input  req_valid, req_addr,
        output req_ready, resp_valid, resp_inst
    );

endinterface

`default_nettype wire

// File: src/dmem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dmem_if
    import soc_pkg::*;
();

    // single data request, driven by the bus port
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_strb;

    // controller side
    logic  req_ready;
    logic  resp_valid;
    word_t resp_rdata;
    logic  resp_err;

    modport master (
        output req_valid, req_write, req_addr, req_wdata, req_strb,
        input  req_ready, resp_valid, resp_rdata, resp_err
    );

    modport slave (
        input  req_valid, req_write, req_addr, req_wdata, req_strb,
        output req_ready, resp_valid, resp_rdata, resp_err
    );

endinterface

`default_nettype wire

// File: src/axil_data_port.sv
`timescale 1ns/10ps
`default_nettype none

module axil_data_port
    import soc_pkg::*;
(
    input  wire        clkConstrained,
    input  wire        rst_n,
    input  wire        awvalid,
    output logic       awready,
    input  wire addr_t awaddr,
    input  wire        wvalid,
    output logic       wready,
    input  wire word_t wdata,
    input  wire strb_t wstrb,
    output logic       bvalid,
    input  wire        bready,
    output axi_resp_t  bresp,
    input  wire        arvalid,
    output logic       arready,
    input  wire addr_t araddr,
    output logic       rvalid,
    input  wire        rready,
    output word_t      rdata,
    output axi_resp_t  rresp,
    dmem_if.master     dmem
);

    typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_t;

    state_t state;
    logic   take_write;
    logic   take_read;
    logic   issued;
    logic   is_write_q;
    logic   err_q;
    addr_t  addr_q;
    word_t  wdata_q;
    strb_t  strb_q;
    word_t  rdata_q;

    // a write needs both AW and W, reads only go when no write is waiting
    assign take_write = (state == IDLE) && awvalid && wvalid;
    assign take_read  = (state == IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = take_write;
    assign wready  = take_write;
    assign arready = take_read;

    // one request per transaction
    assign dmem.req_valid = (state == ACCESS) && !issued;
    assign dmem.req_write = is_write_q;
    assign dmem.req_addr  = addr_q;
    assign dmem.req_wdata = wdata_q;
    assign dmem.req_strb  = strb_q;

    assign bvalid = (state == RESPOND) && is_write_q;
    assign rvalid = (state == RESPOND) && !is_write_q;
    assign bresp  = err_q ? RESP_SLVERR : RESP_OKAY;
    assign rresp  = err_q ? RESP_SLVERR : RESP_OKAY;
    assign rdata  = rdata_q;

    always_ff @(posedge clkConstrained) begin
        if (!rst_n) begin
            state  <= IDLE;
            issued <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take_write || take_read) begin
                        state  <= ACCESS;
                        issued <= 1'b0;
                    end
                end
                ACCESS: begin
                    if (dmem.req_valid && dmem.req_ready) begin
                        issued <= 1'b1;
                    end
                    if (dmem.resp_valid) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    // hold B or R until the master takes it
                    if ((is_write_q && bready) || (!is_write_q && rready)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (take_write) begin
            is_write_q <= 1'b1;
            addr_q     <= awaddr;
            wdata_q    <= wdata;
            strb_q     <= wstrb;
        end else if (take_read) begin
            is_write_q <= 1'b0;
            addr_q     <= araddr;
        end
        if (dmem.resp_valid) begin
            rdata_q <= dmem.resp_rdata;
            err_q   <= dmem.resp_err;
        end
    end

endmodule

`default_nettype wire

// File: src/mem_controller.sv
`timescale 1ns/10ps
`default_nettype none

module mem_controller
    import soc_pkg::*;
(
    input  wire         clkConstrained,
    input  wire         rst_n,
    dmem_if.slave       dmem,
    ifetch_if.slave     ifetch,
    input  wire mtime_t mtime,
    output logic        timer_irq
);

    word_t    ram [MEM_WORDS];
    word_t    ram_q;
    mtime_t   mtimecmp;
    mem_idx_t ram_idx;
    logic     data_go;
    logic     fetch_go;
    logic     data_is_ram;
    logic     data_is_timer;
    word_t    timer_rdata;
    logic     d_resp_q;
    logic     f_resp_q;
    logic     d_from_ram_q;
    logic     d_err_q;
    word_t    d_reg_rdata_q;

    // byte-lane merge for the 32-bit timer halves
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // data always wins, so the data side never waits
    assign dmem.req_ready   = 1'b1;
    assign ifetch.req_ready = !dmem.req_valid;

    assign data_go  = dmem.req_valid;
    assign fetch_go = ifetch.req_valid && ifetch.req_ready;

    // one RAM port shared by both sides, upper address bits ignored
    assign ram_idx = data_go ? dmem.req_addr[MEM_IDX_W+1:2]
                             : ifetch.req_addr[MEM_IDX_W+1:2];

    assign data_is_ram = (dmem.req_addr < RAM_LIMIT);

    always_comb begin
        data_is_timer = 1'b1;
        timer_rdata   = '0;
        case (dmem.req_addr)
            ADDR_MTIME_LO:    timer_rdata = mtime[31:0];
            ADDR_MTIME_HI:    timer_rdata = mtime[63:32];
            ADDR_MTIMECMP_LO: timer_rdata = mtimecmp[31:0];
            ADDR_MTIMECMP_HI: timer_rdata = mtimecmp[63:32];
            default:          data_is_timer = 1'b0;
        endcase
    end

    always_ff @(posedge clkConstrained) begin
        if (data_go && dmem.req_write && data_is_ram) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (dmem.req_strb[b]) begin
                    ram[ram_idx][b*8 +: 8] <= dmem.req_wdata[b*8 +: 8];
                end
            end
        end
        ram_q <= ram[ram_idx];
    end

    // mtime writes are dropped, only the compare register is writable
    always_ff @(posedge clkConstrained) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (data_go && dmem.req_write) begin
            if (dmem.req_addr == ADDR_MTIMECMP_LO) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], dmem.req_wdata, dmem.req_strb);
            end else if (dmem.req_addr == ADDR_MTIMECMP_HI) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], dmem.req_wdata, dmem.req_strb);
            end
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (!rst_n) begin
            d_resp_q  <= 1'b0;
            f_resp_q  <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            d_resp_q  <= data_go;
            f_resp_q  <= fetch_go;
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clkConstrained) begin
        d_from_ram_q  <= data_is_ram;
        d_err_q       <= !(data_is_ram || data_is_timer);
        d_reg_rdata_q <= timer_rdata;
    end

    // unmapped reads come back as zero through d_reg_rdata_q
    assign dmem.resp_valid = d_resp_q;
    assign dmem.resp_rdata = d_from_ram_q ? ram_q : d_reg_rdata_q;
    assign dmem.resp_err   = d_err_q;

    assign ifetch.resp_valid = f_resp_q;
    assign ifetch.resp_inst  = ram_q;

endmodule

`default_nettype wire

// File: src/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_queue
    import soc_pkg::*;
(
    input  wire        clkConstrained,
    input  wire        rst_n,
    input  wire        fetch_valid,
    input  wire addr_t fetch_addr,
    output logic       fetch_done,
    output inst_t      fetch_inst,
    ifetch_if.master   ifetch
);

    inst_t                  q_inst [QUEUE_DEPTH];
    addr_t                  q_tag [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] q_valid;
    qidx_t                  head;
    qidx_t                  tail;
    qcnt_t                  occupancy;
    addr_t                  next_addr;
    addr_t                  pend_addr;
    addr_t                  expect_addr;
    logic                   inflight;
    logic                   head_valid;
    logic                   head_hit;
    logic                   flush;
    logic                   pop;
    logic                   issue;
    logic                   fill;

    assign occupancy  = qcnt_t'($countones(q_valid));
    assign head_valid = q_valid[head];
    assign head_hit   = head_valid && (q_tag[head] == fetch_addr);

    // address the next entry will carry when the queue is empty
    assign expect_addr = inflight ? pend_addr : next_addr;

    assign flush = fetch_valid && (head_valid ? !head_hit : (expect_addr != fetch_addr));
    assign pop   = fetch_valid && head_hit;

    assign fetch_done = pop;
    assign fetch_inst = q_inst[head];

    // keep one slot per request still in flight
    assign ifetch.req_valid = !flush &&
                              ((occupancy + qcnt_t'(inflight)) < qcnt_t'(QUEUE_DEPTH));
    assign ifetch.req_addr  = next_addr;

    assign issue = ifetch.req_valid && ifetch.req_ready;
    assign fill  = ifetch.resp_valid && inflight && !flush;

    always_ff @(posedge clkConstrained) begin
        if (!rst_n) begin
            q_valid   <= '0;
            head      <= '0;
            tail      <= '0;
            next_addr <= '0;
            inflight  <= 1'b0;
        end else if (flush) begin
            // redirect, a response landing now is dropped
            q_valid   <= '0;
            head      <= '0;
            tail      <= '0;
            next_addr <= fetch_addr;
            inflight  <= 1'b0;
        end else begin
            inflight <= issue;
            if (issue) begin
                next_addr <= next_addr + addr_t'(INST_STEP);
            end
            if (fill) begin
                q_valid[tail] <= 1'b1;
                tail          <= tail + qidx_t'(1);
            end
            if (pop) begin
                q_valid[head] <= 1'b0;
                head          <= head + qidx_t'(1);
            end
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (issue) begin
            pend_addr <= next_addr;
        end
        if (fill) begin
            q_inst[tail] <= ifetch.resp_inst;
            q_tag[tail]  <= pend_addr;
        end
    end

endmodule

`default_nettype wire

// File: src/time_base.sv
`timescale 1ns/10ps
`default_nettype none

module time_base
    import soc_pkg::*;
(
    input  wire    clkConstrained,
    input  wire    rst_n,
    output mtime_t mtime
);

    us_cnt_t cyc_cnt;
    logic    us_tick;

    // one tick per microsecond of system clock
    assign us_tick = (cyc_cnt == us_cnt_t'(FMAX_MHZ - 1));

    always_ff @(posedge clkConstrained) begin
        if (!rst_n) begin
            cyc_cnt <= '0;
            mtime   <= '0;
        end else if (us_tick) begin
            cyc_cnt <= '0;
            mtime   <= mtime + mtime_t'(1);
        end else begin
            cyc_cnt <= cyc_cnt + us_cnt_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_top
    import soc_pkg::*;
(
    input  wire        clkConstrained,
    input  wire        rst_n,
    input  wire        awvalid,
    output logic       awready,
    input  wire addr_t awaddr,
    input  wire        wvalid,
    output logic       wready,
    input  wire word_t wdata,
    input  wire strb_t wstrb,
    output logic       bvalid,
    input  wire        bready,
    output axi_resp_t  bresp,
    input  wire        arvalid,
    output logic       arready,
    input  wire addr_t araddr,
    output logic       rvalid,
    input  wire        rready,
    output word_t      rdata,
    output axi_resp_t  rresp,
    input  wire        fetch_valid,
    input  wire addr_t fetch_addr,
    output logic       fetch_done,
    output inst_t      fetch_inst,
    output logic       timer_irq
);

    mtime_t mtime;

    dmem_if   u_dmem_if ();
    ifetch_if u_ifetch_if ();

    // data side, bus to memory
    axil_data_port u_axil_data_port (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .dmem           (u_dmem_if.master)
    );

    mem_controller u_mem_controller (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .dmem           (u_dmem_if.slave),
        .ifetch         (u_ifetch_if.slave),
        .mtime          (mtime),
        .timer_irq      (timer_irq)
    );

    time_base u_time_base (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .mtime          (mtime)
    );

    // fetch side towards the core
    inst_queue u_inst_queue (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_addr     (fetch_addr),
        .fetch_done     (fetch_done),
        .fetch_inst     (fetch_inst),
        .ifetch         (u_ifetch_if.master)
    );

endmodule

`default_nettype wire

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// operations a table entry can ask for
typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_LOAD,
    OP_FETCH,
    OP_MTIME,
    OP_IRQ
} op_t;

typedef struct packed {
    op_t       op;
    addr_t     addr;
    word_t     data;
    strb_t     strb;
    word_t     exp_data;
    axi_resp_t exp_resp;
} vec_t;

localparam int    TIMEOUT_CYCLES = 200;
localparam int    RESET_CYCLES   = 10;
localparam int    SEED           = 37222;
localparam addr_t ADDR_UNMAPPED  = 32'h0000_2000;

vec_t vectors[$];

task automatic add_vector(input op_t op, input addr_t addr, input word_t data,
                          input strb_t strb, input word_t exp_data,
                          input axi_resp_t exp_resp);
    vec_t v;
    v.op       = op;
    v.addr     = addr;
    v.data     = data;
    v.strb     = strb;
    v.exp_data = exp_data;
    v.exp_resp = exp_resp;
    vectors.push_back(v);
endtask

task automatic build_vectors();
    // op, address, data, strobe, expected data outside RAM, expected response
    add_vector(OP_WRITE, 32'h0000_0000, 32'h1357_9BDF, 4'hF,    '0, RESP_OKAY);
    add_vector(OP_WRITE, 32'h0000_0040, 32'h1122_3344, 4'hF,    '0, RESP_OKAY);
    add_vector(OP_READ,  32'h0000_0040, '0,            '0,      '0, RESP_OKAY);
    add_vector(OP_WRITE, 32'h0000_0040, 32'hAABB_CCDD, 4'b0101, '0, RESP_OKAY);
    add_vector(OP_READ,  32'h0000_0040, '0,            '0,      '0, RESP_OKAY);
    add_vector(OP_WRITE, 32'h0000_0044, 32'hDEAD_BEEF, 4'hF,    '0, RESP_OKAY);
    add_vector(OP_WRITE, 32'h0000_0044, 32'h0000_7700, 4'b0010, '0, RESP_OKAY);
    add_vector(OP_WRITE, 32'h0000_0044, 32'h5A00_0000, 4'b1000, '0, RESP_OKAY);
    add_vector(OP_READ,  32'h0000_0044, '0,            '0,      '0, RESP_OKAY);
    add_vector(OP_WRITE, 32'h0000_03FC, 32'hCAFE_F00D, 4'hF,    '0, RESP_OKAY);
    add_vector(OP_READ,  32'h0000_03FC, '0,            '0,      '0, RESP_OKAY);
    // unmapped, both alias RAM word 0 in the low bits
    add_vector(OP_WRITE, ADDR_UNMAPPED, 32'hFFFF_FFFF, 4'hF,    '0, RESP_SLVERR);
    add_vector(OP_READ,  ADDR_UNMAPPED, '0,            '0,      '0, RESP_SLVERR);
    add_vector(OP_WRITE, 32'h0000_0400, 32'h0F0F_0F0F, 4'hF,    '0, RESP_SLVERR);
    add_vector(OP_READ,  32'h0000_0000, '0,            '0,      '0, RESP_OKAY);
    // instruction words go in before any fetch touches them
    for (int a = 32'h100; a <= 32'h110; a += 4) begin
        add_vector(OP_LOAD, addr_t'(a), '0, 4'hF, '0, RESP_OKAY);
    end
    for (int a = 32'h200; a <= 32'h208; a += 4) begin
        add_vector(OP_LOAD, addr_t'(a), '0, 4'hF, '0, RESP_OKAY);
    end
    for (int a = 32'h100; a <= 32'h110; a += 4) begin
        add_vector(OP_FETCH, addr_t'(a), '0, '0, '0, RESP_OKAY);
    end
    add_vector(OP_FETCH, 32'h0000_0200, '0, '0, '0, RESP_OKAY);
    add_vector(OP_FETCH, 32'h0000_0204, '0, '0, '0, RESP_OKAY);
    add_vector(OP_FETCH, 32'h0000_0208, '0, '0, '0, RESP_OKAY);
    add_vector(OP_FETCH, 32'h0000_0104, '0, '0, '0, RESP_OKAY);
    add_vector(OP_FETCH, 32'h0000_0108, '0, '0, '0, RESP_OKAY);
    // timer registers and interrupt
    add_vector(OP_IRQ,   '0,               '0,            '0,   32'h0,         RESP_OKAY);
    add_vector(OP_WRITE, ADDR_MTIMECMP_HI, 32'h0000_1234, 4'hF, '0,            RESP_OKAY);
    add_vector(OP_WRITE, ADDR_MTIMECMP_LO, 32'h89AB_CDEF, 4'hF, '0,            RESP_OKAY);
    add_vector(OP_READ,  ADDR_MTIMECMP_HI, '0,            '0,   32'h0000_1234, RESP_OKAY);
    add_vector(OP_READ,  ADDR_MTIMECMP_LO, '0,            '0,   32'h89AB_CDEF, RESP_OKAY);
    add_vector(OP_IRQ,   '0,               '0,            '0,   32'h0,         RESP_OKAY);
    add_vector(OP_MTIME, '0,               32'd40,        '0,   '0,            RESP_OKAY);
    add_vector(OP_READ,  ADDR_MTIME_HI,    '0,            '0,   32'h0,         RESP_OKAY);
    add_vector(OP_WRITE, ADDR_MTIMECMP_HI, 32'h0,         4'hF, '0,            RESP_OKAY);
    add_vector(OP_WRITE, ADDR_MTIMECMP_LO, 32'h5,         4'hF, '0,            RESP_OKAY);
    add_vector(OP_READ,  ADDR_MTIMECMP_LO, '0,            '0,   32'h5,         RESP_OKAY);
    add_vector(OP_IRQ,   '0,               '0,            '0,   32'h1,         RESP_OKAY);
    add_vector(OP_WRITE, ADDR_MTIMECMP_HI, 32'hFFFF_FFFF, 4'hF, '0,            RESP_OKAY);
    add_vector(OP_WRITE, ADDR_MTIMECMP_LO, 32'hFFFF_FFFF, 4'hF, '0,            RESP_OKAY);
    add_vector(OP_IRQ,   '0,               '0,            '0,   32'h0,         RESP_OKAY);
    add_vector(OP_READ,  ADDR_MTIMECMP_HI, '0,            '0,   32'hFFFF_FFFF, RESP_OKAY);
endtask

`endif

// File: testbench/tb_fetch_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_mem
    import soc_pkg::*;
();

    logic      clkConstrained;
    logic      rst_n;
    logic      awvalid;
    logic      awready;
    addr_t     awaddr;
    logic      wvalid;
    logic      wready;
    word_t     wdata;
    strb_t     wstrb;
    logic      bvalid;
    logic      bready;
    axi_resp_t bresp;
    logic      arvalid;
    logic      arready;
    addr_t     araddr;
    logic      rvalid;
    logic      rready;
    word_t     rdata;
    axi_resp_t rresp;
    logic      fetch_valid;
    addr_t     fetch_addr;
    logic      fetch_done;
    inst_t     fetch_inst;
    logic      timer_irq;

    // expected RAM contents
    word_t shadow [MEM_WORDS];

    `include "tb_vectors.svh"

    fetch_mem_top u_fetch_mem_top (
        .clkConstrained (clkConstrained),
        .rst_n          (rst_n),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .fetch_valid    (fetch_valid),
        .fetch_addr     (fetch_addr),
        .fetch_done     (fetch_done),
        .fetch_inst     (fetch_inst),
        .timer_irq      (timer_irq)
    );

    initial begin
        clkConstrained = 1'b0;
        forever #50 clkConstrained = ~clkConstrained;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_drive_point();
        @(posedge clkConstrained);
        #1;
    endtask

    function automatic word_t apply_strobe(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic axi_write(input addr_t addr, input word_t data, input strb_t strb,
                             output axi_resp_t resp);
        int n;
        int stall;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clkConstrained);
        while (!(awready && wready)) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: write address/data never accepted at %h", addr));
            end
            @(negedge clkConstrained);
        end
        next_drive_point();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        stall = int'($urandom % 4);
        n = 0;
        @(negedge clkConstrained);
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: no write response for address %h", addr));
            end
            @(negedge clkConstrained);
        end
        repeat (stall) @(negedge clkConstrained);
        next_drive_point();
        bready = 1'b1;
        @(negedge clkConstrained);
        if (!bvalid) begin
            abort_run("write response dropped before the master took it");
        end
        resp = bresp;
        next_drive_point();
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output word_t data, output axi_resp_t resp);
        int n;
        int stall;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clkConstrained);
        while (!arready) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: read address never accepted at %h", addr));
            end
            @(negedge clkConstrained);
        end
        next_drive_point();
        arvalid = 1'b0;
        stall = int'($urandom % 4);
        n = 0;
        @(negedge clkConstrained);
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: no read data for address %h", addr));
            end
            @(negedge clkConstrained);
        end
        repeat (stall) @(negedge clkConstrained);
        next_drive_point();
        rready = 1'b1;
        @(negedge clkConstrained);
        if (!rvalid) begin
            abort_run("read data dropped before the master took it");
        end
        data = rdata;
        resp = rresp;
        next_drive_point();
        rready = 1'b0;
    endtask

    task automatic fetch_word(input addr_t addr, output inst_t inst);
        int n;
        fetch_addr  = addr;
        fetch_valid = 1'b1;
        n = 0;
        @(negedge clkConstrained);
        while (!fetch_done) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: fetch of address %h never completed", addr));
            end
            @(negedge clkConstrained);
        end
        inst = fetch_inst;
        next_drive_point();
        fetch_valid = 1'b0;
    endtask

    task automatic wait_irq_level(input logic level);
        int n;
        n = 0;
        @(negedge clkConstrained);
        while (timer_irq !== level) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout: timer interrupt never reached level %0b", level));
            end
            @(negedge clkConstrained);
        end
        next_drive_point();
    endtask

    initial begin
        vec_t      v;
        axi_resp_t resp;
        word_t     rd;
        word_t     wr;
        word_t     t_first;
        word_t     t_min;
        inst_t     inst;
        mem_idx_t  idx;
        rst_n       = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        void'($urandom(SEED));
        build_vectors();
        repeat (RESET_CYCLES) @(posedge clkConstrained);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < vectors.size(); i++) begin
            v   = vectors[i];
            idx = v.addr[MEM_IDX_W+1:2];
            case (v.op)
                OP_WRITE, OP_LOAD: begin
                    // loads carry a random instruction word
                    wr = (v.op == OP_LOAD) ? word_t'($urandom) : v.data;
                    axi_write(v.addr, wr, v.strb, resp);
                    check_resp("bresp", resp, v.exp_resp);
                    if (v.addr < RAM_LIMIT) begin
                        shadow[idx] = apply_strobe(shadow[idx], wr, v.strb);
                    end
                end
                OP_READ: begin
                    axi_read(v.addr, rd, resp);
                    check_resp("rresp", resp, v.exp_resp);
                    check_word("rdata", rd, (v.addr < RAM_LIMIT) ? shadow[idx] : v.exp_data);
                end
                OP_FETCH: begin
                    fetch_word(v.addr, inst);
                    check_inst("fetch_inst", inst, inst_t'(shadow[idx]));
                end
                OP_MTIME: begin
                    axi_read(ADDR_MTIME_LO, t_first, resp);
                    check_resp("rresp", resp, RESP_OKAY);
                    repeat (v.data) next_drive_point();
                    axi_read(ADDR_MTIME_LO, rd, resp);
                    check_resp("rresp", resp, RESP_OKAY);
                    // at least one tick for every FMAX_MHZ cycles of the gap
                    t_min = t_first + word_t'(v.data / FMAX_MHZ);
                    if (rd < t_min) begin
                        abort_run($sformatf("ERR time=%0t mtime got=%h expected at least %h",
                                            $time, rd, t_min));
                    end
                end
                OP_IRQ: begin
                    wait_irq_level(v.exp_data[0]);
                end
                default: begin
                    abort_run("unknown operation in the stimulus table");
                end
            endcase
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+testbench
src/soc_pkg.sv
src/ifetch_if.sv
src/dmem_if.sv
src/axil_data_port.sv
src/mem_controller.sv
src/inst_queue.sv
src/time_base.sv
src/fetch_mem_top.sv
testbench/tb_fetch_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch/memory testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f compile.f --top-module tb_fetch_mem \
    -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -qx '>>> PASS' "$LOG"; then
    echo "result: passed"
    exit 0
fi
echo "result: failed"
exit 1
